// File: logic/eboxPkg.sv
package eboxPkg;

  localparam int wordWidth = 36;           // AR, BR, AD and EBUS
  localparam int microWordWidth = 36;
  localparam int scWidth = 10;
  localparam int magicWidth = 9;

  localparam int jFieldLsb = 0;            // Next microaddress
  localparam int jFieldWidth = 11;
  localparam int skipFieldLsb = 11;
  localparam int skipFieldWidth = 3;
  localparam int seqFieldLsb = 14;
  localparam int seqFieldWidth = 2;
  localparam int adFieldLsb = 16;
  localparam int adFieldWidth = 3;
  localparam int arFieldLsb = 19;
  localparam int arFieldWidth = 2;
  localparam int brLoadBit = 21;
  localparam int scFieldLsb = 22;
  localparam int scFieldWidth = 2;
  localparam int magicFieldLsb = 24;       // Bits 33 to 35 are spare

  // Code 0 of every field is the idle choice, so a zero word is a no-op
  localparam logic [seqFieldWidth-1:0] seqNext = 2'd0;
  localparam logic [seqFieldWidth-1:0] seqCall = 2'd1;
  localparam logic [seqFieldWidth-1:0] seqReturn = 2'd2;
  localparam logic [seqFieldWidth-1:0] seqHalt = 2'd3;

  localparam logic [skipFieldWidth-1:0] skipNone = 3'd0;
  localparam logic [skipFieldWidth-1:0] skipAdEq0 = 3'd1;
  localparam logic [skipFieldWidth-1:0] skipAdNeg = 3'd2;
  localparam logic [skipFieldWidth-1:0] skipScNeg = 3'd3;
  localparam logic [skipFieldWidth-1:0] skipScNotNeg = 3'd4;

  localparam logic [adFieldWidth-1:0] adA = 3'd0;
  localparam logic [adFieldWidth-1:0] adAplusB = 3'd1;
  localparam logic [adFieldWidth-1:0] adAminusB = 3'd2;
  localparam logic [adFieldWidth-1:0] adB = 3'd3;
  localparam logic [adFieldWidth-1:0] adAnd = 3'd4;
  localparam logic [adFieldWidth-1:0] adOr = 3'd5;
  localparam logic [adFieldWidth-1:0] adXor = 3'd6;
  localparam logic [adFieldWidth-1:0] adAplus1 = 3'd7;

  localparam logic [arFieldWidth-1:0] arHold = 2'd0;
  localparam logic [arFieldWidth-1:0] arAd = 2'd1;
  localparam logic [arFieldWidth-1:0] arEbus = 2'd2;
  localparam logic [arFieldWidth-1:0] arMagic = 2'd3;

  localparam logic [scFieldWidth-1:0] scHold = 2'd0;
  localparam logic [scFieldWidth-1:0] scLoad = 2'd1;
  localparam logic [scFieldWidth-1:0] scDec = 2'd2;
  localparam logic [scFieldWidth-1:0] scClear = 2'd3;

  typedef union packed {
    logic [magicWidth-1:0] number;         // Unsigned constant for AR
    struct packed {
      logic sign;
      logic [magicWidth-2:0] body;
    } count;                               // Signed start value for SC
  } magicT;

endpackage

// File: logic/controlRam.sv
`timescale 1ns/10ps
module controlRam #(
  parameter int cramDepth = 2048,
  localparam int adrWidth = $clog2(cramDepth)
) (
  input  logic eboxClk,
  input  logic rstN,
  input  logic cramWrEn,                                    // Diagnostic load strobe
  input  logic [adrWidth-1:0] cramWrAdr,
  input  logic [eboxPkg::microWordWidth-1:0] cramWrData,
  input  logic [adrWidth-1:0] nextAdr,
  input  logic running,
  output logic [eboxPkg::microWordWidth-1:0] cramWord
);

  logic [eboxPkg::microWordWidth-1:0] cram [cramDepth];
  logic [eboxPkg::microWordWidth-1:0] wordReg;

  // Diagnostic write port, only used while the box is halted
  always_ff @(posedge eboxClk) begin
    if (cramWrEn) begin
      cram[cramWrAdr] <= cramWrData;
    end
  end

  // The sequencer steers nextAdr to startAdr when a start is taken, so the
  // addressed word is always fetched and the run state picks what goes out
  always_ff @(posedge eboxClk or negedge rstN) begin
    if (!rstN) begin
      wordReg <= '0;
    end else begin
      wordReg <= cram[nextAdr];
    end
  end

  // Halted box sees the all-zero no-op
  assign cramWord = running ? wordReg : '0;

endmodule

// File: logic/microAddress.sv
`timescale 1ns/10ps
module microAddress #(
  parameter int cramDepth = 2048,
  localparam int adrWidth = $clog2(cramDepth)
) (
  input  logic eboxClk,
  input  logic rstN,
  input  logic start,                                       // One-cycle pulse
  input  logic [adrWidth-1:0] startAdr,
  input  logic [eboxPkg::microWordWidth-1:0] cramWord,
  input  logic adEq0,
  input  logic adNeg,
  input  logic scNeg,
  output logic [adrWidth-1:0] nextAdr,
  output logic [adrWidth-1:0] cradr,
  output logic running,
  output logic halted
);

  localparam logic [adrWidth-1:0] adrOne = 1;

  logic [eboxPkg::skipFieldWidth-1:0] skipCode;
  logic [eboxPkg::seqFieldWidth-1:0] seqCode;
  logic [adrWidth-1:0] jAdr;
  logic [adrWidth-1:0] baseAdr;
  logic [adrWidth-1:0] retAdr;
  logic skip;
  logic startTaken;

  assign skipCode = cramWord[eboxPkg::skipFieldLsb +: eboxPkg::skipFieldWidth];
  assign seqCode = cramWord[eboxPkg::seqFieldLsb +: eboxPkg::seqFieldWidth];
  assign jAdr = cramWord[eboxPkg::jFieldLsb +: adrWidth];   // Low bits of J

  always_comb begin
    case (skipCode)
      eboxPkg::skipAdEq0:    skip = adEq0;
      eboxPkg::skipAdNeg:    skip = adNeg;
      eboxPkg::skipScNeg:    skip = scNeg;
      eboxPkg::skipScNotNeg: skip = ~scNeg;
      default:               skip = 1'b0;
    endcase
  end

  assign startTaken = start & ~running;                     // Ignored while running
  assign baseAdr = (seqCode == eboxPkg::seqReturn) ? retAdr : jAdr;
  assign nextAdr = startTaken ? startAdr : (baseAdr | {{(adrWidth-1){1'b0}}, skip});

  always_ff @(posedge eboxClk or negedge rstN) begin
    if (!rstN) begin
      running <= 1'b0;
      cradr <= '0;
      retAdr <= '0;
    end else begin
      if (startTaken) begin
        running <= 1'b1;
      end else if (seqCode == eboxPkg::seqHalt) begin
        running <= 1'b0;                                    // Halt word still executes
      end
      if (running || startTaken) begin
        cradr <= nextAdr;
      end
      if (seqCode == eboxPkg::seqCall) begin
        retAdr <= cradr + adrOne;                           // One level only
      end
    end
  end

  assign halted = ~running;

endmodule

// File: logic/dataPath.sv
`timescale 1ns/10ps
module dataPath (
  input  logic eboxClk,
  input  logic rstN,
  input  logic [eboxPkg::microWordWidth-1:0] cramWord,
  input  logic [0:eboxPkg::wordWidth-1] ebus,
  output logic [0:eboxPkg::wordWidth-1] ar,
  output logic adEq0,
  output logic adNeg
);

  localparam logic [0:eboxPkg::wordWidth-1] wordOne = 1;

  logic [eboxPkg::adFieldWidth-1:0] adCode;
  logic [eboxPkg::arFieldWidth-1:0] arCode;
  logic brLoad;
  eboxPkg::magicT magic;
  logic [0:eboxPkg::wordWidth-1] magicWord;
  logic [0:eboxPkg::wordWidth-1] br;
  logic [0:eboxPkg::wordWidth-1] ad;

  assign adCode = cramWord[eboxPkg::adFieldLsb +: eboxPkg::adFieldWidth];
  assign arCode = cramWord[eboxPkg::arFieldLsb +: eboxPkg::arFieldWidth];
  assign brLoad = cramWord[eboxPkg::brLoadBit];
  assign magic = cramWord[eboxPkg::magicFieldLsb +: eboxPkg::magicWidth];

  // Magic number lands in the right end of AR
  assign magicWord = {{(eboxPkg::wordWidth - eboxPkg::magicWidth){1'b0}}, magic.number};

  // AD function unit, arithmetic wraps at 36 bits
  always_comb begin
    case (adCode)
      eboxPkg::adA:       ad = ar;
      eboxPkg::adAplusB:  ad = ar + br;
      eboxPkg::adAminusB: ad = ar - br;
      eboxPkg::adB:       ad = br;
      eboxPkg::adAnd:     ad = ar & br;
      eboxPkg::adOr:      ad = ar | br;
      eboxPkg::adXor:     ad = ar ^ br;
      default:            ad = ar + wordOne;                // adAplus1
    endcase
  end

  assign adEq0 = (ad == '0);
  assign adNeg = ad[0];                                     // Bit 0 is the sign

  always_ff @(posedge eboxClk or negedge rstN) begin
    if (!rstN) begin
      ar <= '0;
    end else begin
      case (arCode)
        eboxPkg::arAd:    ar <= ad;
        eboxPkg::arEbus:  ar <= ebus;
        eboxPkg::arMagic: ar <= magicWord;
        default:          ar <= ar;                         // arHold
      endcase
    end
  end

  // BR takes AR as it was before this edge
  always_ff @(posedge eboxClk or negedge rstN) begin
    if (!rstN) begin
      br <= '0;
    end else if (brLoad) begin
      br <= ar;
    end
  end

endmodule

// File: logic/stepCounter.sv
`timescale 1ns/10ps
module stepCounter (
  input  logic eboxClk,
  input  logic rstN,
  input  logic [eboxPkg::microWordWidth-1:0] cramWord,
  output logic scNeg
);

  localparam int extWidth = eboxPkg::scWidth - eboxPkg::magicWidth + 1;
  localparam logic [0:eboxPkg::scWidth-1] scOne = 1;

  logic [eboxPkg::scFieldWidth-1:0] scCode;
  eboxPkg::magicT magic;
  logic [0:eboxPkg::scWidth-1] scLoadValue;
  logic [0:eboxPkg::scWidth-1] sc;

  assign scCode = cramWord[eboxPkg::scFieldLsb +: eboxPkg::scFieldWidth];
  assign magic = cramWord[eboxPkg::magicFieldLsb +: eboxPkg::magicWidth];
  assign scLoadValue = {{extWidth{magic.count.sign}}, magic.count.body};  // Sign-extended

  always_ff @(posedge eboxClk or negedge rstN) begin
    if (!rstN) begin
      sc <= '0;
    end else begin
      case (scCode)
        eboxPkg::scLoad:  sc <= scLoadValue;
        eboxPkg::scDec:   sc <= sc - scOne;                 // Wraps at 10 bits
        eboxPkg::scClear: sc <= '0;
        default:          sc <= sc;
      endcase
    end
  end

  assign scNeg = sc[0];

endmodule

// File: logic/ebox.sv
`timescale 1ns/10ps
module ebox #(
  parameter int cramDepth = 2048,
  localparam int adrWidth = $clog2(cramDepth)
) (
  input  logic eboxClk,
  input  logic rstN,
  input  logic start,
  input  logic [adrWidth-1:0] startAdr,
  input  logic cramWrEn,
  input  logic [adrWidth-1:0] cramWrAdr,
  input  logic [eboxPkg::microWordWidth-1:0] cramWrData,
  input  logic [0:eboxPkg::wordWidth-1] ebus,
  output logic [0:eboxPkg::wordWidth-1] ar,
  output logic halted,                                      // High when not running
  output logic [adrWidth-1:0] cradr
);

  logic [adrWidth-1:0] nextAdr;
  logic [eboxPkg::microWordWidth-1:0] cramWord;             // Current microword
  logic running;
  logic adEq0;
  logic adNeg;
  logic scNeg;

  controlRam #(.cramDepth(cramDepth)) controlRam0 (
    .eboxClk    (eboxClk),
    .rstN       (rstN),
    .cramWrEn   (cramWrEn),
    .cramWrAdr  (cramWrAdr),
    .cramWrData (cramWrData),
    .nextAdr    (nextAdr),
    .running    (running),
    .cramWord   (cramWord));

  microAddress #(.cramDepth(cramDepth)) microAddress0 (
    .eboxClk  (eboxClk),
    .rstN     (rstN),
    .start    (start),
    .startAdr (startAdr),
    .cramWord (cramWord),
    .adEq0    (adEq0),
    .adNeg    (adNeg),
    .scNeg    (scNeg),
    .nextAdr  (nextAdr),
    .cradr    (cradr),
    .running  (running),
    .halted   (halted));

  dataPath dataPath0 (
    .eboxClk  (eboxClk),
    .rstN     (rstN),
    .cramWord (cramWord),
    .ebus     (ebus),
    .ar       (ar),
    .adEq0    (adEq0),
    .adNeg    (adNeg));

  stepCounter stepCounter0 (
    .eboxClk  (eboxClk),
    .rstN     (rstN),
    .cramWord (cramWord),
    .scNeg    (scNeg));

endmodule

// File: testbench/clockGen.sv
`timescale 1ns/10ps
module clockGen #(
  parameter int halfPeriod = 20                 // 40 ns clock
) (
  output logic eboxClk,
  output logic rstN
);

  initial begin
    eboxClk = 1'b0;
    forever #halfPeriod eboxClk = ~eboxClk;
  end

  initial begin
    rstN = 1'b0;
    repeat (2) @(posedge eboxClk);              // Two cycles in reset
    rstN <= 1'b1;
  end

endmodule

// File: testbench/eboxChk.sv
`timescale 1ns/10ps
module eboxChk (
  input logic eboxClk,
  input logic rstN,
  input logic start,
  input logic cramWrEn,
  input logic running,
  input logic halted,
  input logic [0:eboxPkg::wordWidth-1] ar
);

  // A stopped box leaves halt only on a start, and AR keeps its value
  stopStaysStopped: assert property (@(posedge eboxClk) disable iff (!rstN)
    (!running && !start) |=> (halted && $stable(ar)))
    else $error("stopped box left halt or changed AR without a start");

  // Diagnostic loads only while the box is stopped
  cramWriteWhileHalted: assert property (@(posedge eboxClk) disable iff (!rstN)
    cramWrEn |-> halted)
    else $error("CRAM written while the box is running");

  startLeavesHalt: assert property (@(posedge eboxClk) disable iff (!rstN)
    (start && halted) |=> !halted)
    else $error("start pulse did not bring the box out of halt");

endmodule

// File: testbench/eboxTb.sv
`timescale 1ns/10ps
module eboxTb;

  localparam int cramDepth = 2048;
  localparam int adrWidth = $clog2(cramDepth);
  localparam int numTests = 11;
  localparam int maxWords = 8;
  localparam int cycleLimit = numTests * 80;

  logic eboxClk;
  logic rstN;
  logic start;
  logic [adrWidth-1:0] startAdr;
  logic cramWrEn;
  logic [adrWidth-1:0] cramWrAdr;
  logic [eboxPkg::microWordWidth-1:0] cramWrData;
  logic [35:0] ebus;
  logic [35:0] ar;
  logic halted;
  logic [adrWidth-1:0] cradr;

  string testName [numTests];
  logic [35:0] progWord [numTests][maxWords];
  int progAdr [numTests][maxWords];
  int progLen [numTests];
  logic [35:0] ebusVal [numTests];
  logic [35:0] expectAr [numTests];
  int expectCradr [numTests];                      // Halt words jump to themselves

  integer seed = 32'hf8f9;
  int errorCount = 0;
  int passCount = 0;
  int failCount = 0;
  int cycleCount = 0;

  clockGen clockGen0 (.eboxClk(eboxClk), .rstN(rstN));

  ebox #(.cramDepth(cramDepth)) ebox_i (
    .eboxClk    (eboxClk),
    .rstN       (rstN),
    .start      (start),
    .startAdr   (startAdr),
    .cramWrEn   (cramWrEn),
    .cramWrAdr  (cramWrAdr),
    .cramWrData (cramWrData),
    .ebus       (ebus),
    .ar         (ar),
    .halted     (halted),
    .cradr      (cradr));

  bind ebox eboxChk eboxChk0 (
    .eboxClk  (eboxClk),
    .rstN     (rstN),
    .start    (start),
    .cramWrEn (cramWrEn),
    .running  (running),
    .halted   (halted),
    .ar       (ar));

  // Unnamed fields stay at code 0, the idle choice
  function automatic logic [eboxPkg::microWordWidth-1:0] makeWord(
    input logic [eboxPkg::seqFieldWidth-1:0] seq = eboxPkg::seqNext,
    input logic [eboxPkg::skipFieldWidth-1:0] skip = eboxPkg::skipNone,
    input int j = 0,
    input logic [eboxPkg::adFieldWidth-1:0] adSel = eboxPkg::adA,
    input logic [eboxPkg::arFieldWidth-1:0] arSel = eboxPkg::arHold,
    input logic brLd = 1'b0,
    input logic [eboxPkg::scFieldWidth-1:0] scSel = eboxPkg::scHold,
    input int magic = 0
  );
    logic [eboxPkg::microWordWidth-1:0] word;
    word = '0;
    word[eboxPkg::jFieldLsb +: eboxPkg::jFieldWidth] = j[eboxPkg::jFieldWidth-1:0];
    word[eboxPkg::skipFieldLsb +: eboxPkg::skipFieldWidth] = skip;
    word[eboxPkg::seqFieldLsb +: eboxPkg::seqFieldWidth] = seq;
    word[eboxPkg::adFieldLsb +: eboxPkg::adFieldWidth] = adSel;
    word[eboxPkg::arFieldLsb +: eboxPkg::arFieldWidth] = arSel;
    word[eboxPkg::brLoadBit] = brLd;
    word[eboxPkg::scFieldLsb +: eboxPkg::scFieldWidth] = scSel;
    word[eboxPkg::magicFieldLsb +: eboxPkg::magicWidth] = magic[eboxPkg::magicWidth-1:0];
    return word;
  endfunction

  task automatic addWord(input int row, input int adr, input logic [35:0] word);
    progWord[row][progLen[row]] = word;
    progAdr[row][progLen[row]] = adr;
    progLen[row] = progLen[row] + 1;
  endtask

  // Row r lives at CRAM address r * 16 and starts there
  task automatic buildTable();
    string logicName [4] = '{"andEbus", "orEbus", "xorEbus", "subEbus"};
    logic [2:0] logicFn [4] = '{eboxPkg::adAnd, eboxPkg::adOr, eboxPkg::adXor,
                                eboxPkg::adAminusB};
    logic [63:0] rnd;
    logic [35:0] e;
    int b;
    int n;
    int k;
    for (int r = 0; r < numTests; r++) begin
      progLen[r] = 0;
      ebusVal[r] = '0;
    end
    testName[0] = "addConst";
    addWord(0, 0, makeWord(.arSel(eboxPkg::arMagic), .magic(123), .j(1)));
    addWord(0, 1, makeWord(.brLd(1'b1), .j(2)));
    addWord(0, 2, makeWord(.arSel(eboxPkg::arMagic), .magic(456), .j(3)));
    addWord(0, 3, makeWord(.adSel(eboxPkg::adAplusB), .arSel(eboxPkg::arAd), .j(4)));
    addWord(0, 4, makeWord(.seq(eboxPkg::seqHalt), .j(4)));
    expectAr[0] = 36'd579;
    expectCradr[0] = 4;
    for (int r = 1; r <= 4; r++) begin
      b = r * 16;
      rnd = {$random(seed), $random(seed)};
      e = rnd[35:0];
      testName[r] = logicName[r-1];
      ebusVal[r] = e;
      addWord(r, b, makeWord(.arSel(eboxPkg::arEbus), .j(b + 1)));
      addWord(r, b + 1, makeWord(.brLd(1'b1), .arSel(eboxPkg::arMagic), .magic(437), .j(b + 2)));
      addWord(r, b + 2, makeWord(.adSel(logicFn[r-1]), .arSel(eboxPkg::arAd), .j(b + 3)));
      addWord(r, b + 3, makeWord(.seq(eboxPkg::seqHalt), .j(b + 3)));
      case (r)
        1: expectAr[r] = 36'd437 & e;
        2: expectAr[r] = 36'd437 | e;
        3: expectAr[r] = 36'd437 ^ e;
        default: expectAr[r] = 36'd437 - e;          // Wraps at 36 bits
      endcase
      expectCradr[r] = b + 3;
    end
    for (int r = 5; r <= 6; r++) begin
      b = r * 16;
      testName[r] = (r == 5) ? "skipTaken" : "skipNotTaken";
      addWord(r, b, makeWord(.arSel(eboxPkg::arMagic), .magic((r == 5) ? 0 : 7), .j(b + 1)));
      addWord(r, b + 1, makeWord(.skip(eboxPkg::skipAdEq0), .j(b + 2)));
      addWord(r, b + 2, makeWord(.seq(eboxPkg::seqHalt), .arSel(eboxPkg::arMagic), .magic(9),
                                 .j(b + 2)));
      addWord(r, b + 3, makeWord(.seq(eboxPkg::seqHalt), .arSel(eboxPkg::arMagic), .magic(5),
                                 .j(b + 3)));
      expectAr[r] = (r == 5) ? 36'd5 : 36'd9;
      expectCradr[r] = (r == 5) ? b + 3 : b + 2;     // Odd word only on the taken skip
    end
    // Multiply by repeated addition, SC counts the passes
    for (int r = 7; r <= 8; r++) begin
      b = r * 16;
      n = (r == 7) ? 3 : 6;
      k = (r == 7) ? 37 : 200;
      testName[r] = (r == 7) ? "scLoop3" : "scLoop6";
      addWord(r, b, makeWord(.arSel(eboxPkg::arMagic), .magic(k), .j(b + 1)));
      addWord(r, b + 1, makeWord(.brLd(1'b1), .scSel(eboxPkg::scLoad), .magic(n - 1), .j(b + 5)));
      addWord(r, b + 5, makeWord(.arSel(eboxPkg::arMagic), .magic(0), .j(b + 3)));
      addWord(r, b + 3, makeWord(.adSel(eboxPkg::adAplusB), .arSel(eboxPkg::arAd),
                                 .scSel(eboxPkg::scDec), .j(b + 4)));
      addWord(r, b + 4, makeWord(.skip(eboxPkg::skipScNotNeg), .j(b + 2)));  // Back to b + 3
      addWord(r, b + 2, makeWord(.seq(eboxPkg::seqHalt), .j(b + 2)));
      expectAr[r] = 36'(n * k);
      expectCradr[r] = b + 2;
    end
    b = 9 * 16;
    rnd = {$random(seed), $random(seed)};
    e = rnd[35:0];
    testName[9] = "callReturn";
    ebusVal[9] = e;
    addWord(9, b, makeWord(.arSel(eboxPkg::arEbus), .j(b + 1)));
    addWord(9, b + 1, makeWord(.seq(eboxPkg::seqCall), .j(b + 8)));
    addWord(9, b + 2, makeWord(.seq(eboxPkg::seqCall), .j(b + 8)));
    addWord(9, b + 3, makeWord(.seq(eboxPkg::seqHalt), .j(b + 3)));
    addWord(9, b + 8, makeWord(.seq(eboxPkg::seqReturn), .adSel(eboxPkg::adAplus1),
                               .arSel(eboxPkg::arAd)));
    expectAr[9] = e + 36'd2;
    expectCradr[9] = b + 3;
    testName[10] = "haltOnly";
    addWord(10, 10 * 16, makeWord(.seq(eboxPkg::seqHalt), .j(10 * 16)));
    expectAr[10] = expectAr[9];                      // AR left from the row before
    expectCradr[10] = 10 * 16;
  endtask

  task automatic checkValue(
    input string name,
    input logic [35:0] expected,
    input logic [35:0] actual
  );
    if (actual !== expected) begin
      errorCount++;
      $display("Mismatch in %0s: expected %09h, actual %09h", name, expected, actual);
    end
  endtask

  task automatic reportTest(input string name, input int errorsBefore);
    if (errorCount == errorsBefore) begin
      passCount++;
      $display("Test %0s: ok", name);
    end else begin
      failCount++;
      $display("Test %0s: FAILED", name);
    end
  endtask

  task automatic runTest(input int r);
    int errorsBefore;
    errorsBefore = errorCount;
    for (int i = 0; i < progLen[r]; i++) begin
      @(posedge eboxClk);
      cramWrEn <= 1'b1;
      cramWrAdr <= adrWidth'(progAdr[r][i]);
      cramWrData <= progWord[r][i];
    end
    @(posedge eboxClk);
    cramWrEn <= 1'b0;
    ebus <= ebusVal[r];
    startAdr <= adrWidth'(r * 16);
    start <= 1'b1;
    @(posedge eboxClk);
    start <= 1'b0;
    @(negedge eboxClk);
    while (!halted) begin
      @(negedge eboxClk);
    end
    checkValue(testName[r], expectAr[r], ar);
    checkValue({testName[r], " cradr"}, 36'(expectCradr[r]), 36'(cradr));
    reportTest(testName[r], errorsBefore);
  endtask

  initial begin
    while (cycleCount < cycleLimit) begin
      @(posedge eboxClk);
      cycleCount++;
    end
    $display("Timeout: the tests did not finish within %0d cycles", cycleLimit);
    $display("Verification failed");
    $finish;
  end

  initial begin
    start = 1'b0;
    startAdr = '0;
    cramWrEn = 1'b0;
    cramWrAdr = '0;
    cramWrData = '0;
    ebus = '0;
    buildTable();
    wait (rstN === 1'b1);
    @(negedge eboxClk);
    checkValue("resetState", 36'd1, 36'(halted));
    checkValue("resetState", 36'd0, ar);
    checkValue("resetState", 36'd0, 36'(cradr));
    reportTest("resetState", 0);
    for (int r = 0; r < numTests; r++) begin
      runTest(r);
    end
    $display("%0d tests passed, %0d tests failed", passCount, failCount);
    if (errorCount == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// File: tb.f
logic/eboxPkg.sv
logic/controlRam.sv
logic/microAddress.sv
logic/dataPath.sv
logic/stepCounter.sv
logic/ebox.sv
testbench/clockGen.sv
testbench/eboxChk.sv
testbench/eboxTb.sv

// File: run.sh
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the output
verilator --binary --assert --top-module eboxTb -f tb.f -o eboxSim &&
  ./obj_dir/eboxSim | tee /dev/stderr | grep -qx "Verification passed" &&
  exit 0 || { echo "Simulation did not pass"; exit 1; }
